// ==== board_top.f ====
+incdir+tests
common/board_pkg.sv
common/audio_pkg.sv
common/sample_if.sv
i2s/i2s_mic_receiver.sv
i2s/i2s_audio_out.sv
source/tone_source.sv
source/audio_mixer.sv
display/seven_seg_display.sv
source/board_top.sv
tests/board_top_tb.sv

// ==== Bender.yml ====
package:
  name: board_top

sources:
  - common/board_pkg.sv
  - common/audio_pkg.sv
  - common/sample_if.sv
  - i2s/i2s_mic_receiver.sv
  - i2s/i2s_audio_out.sv
  - source/tone_source.sv
  - source/audio_mixer.sv
  - display/seven_seg_display.sv
  - source/board_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/board_top_tb.sv

// ==== tests/i2s_bus_model.svh ====
`ifndef i2s_bus_model_svh
`define i2s_bus_model_svh

// ------------------------------
// Microphone side
// ------------------------------

// Mirror of the sck period within the 64-period frame
int          mic_slot     = 0;
logic        mic_sck_seen = 1'b0;
mic_sample_t mic_word     = '0;

// Called on each falling clk edge, sd moves after a falling sck
task automatic drive_mic_sd ();
    if (mic_sck_seen && !mic_sck)
    begin
        mic_slot = (mic_slot + 1) % 64;

        // Period 1 carries the MSB of a new sample
        if (mic_slot == 1)
        begin
            mic_word = next_mic_sample ();
            sent_q.push_back (mic_word);
        end

        if (mic_slot >= 1 && mic_slot <= 24 && mic_ws !== 1'b0)
            report_failure ("microphone ws was high during a left-channel data bit");
    end

    mic_sck_seen = mic_sck;

    if (mic_slot >= 1 && mic_slot <= 24)
        mic_sd = mic_word [24 - mic_slot];
    else
        mic_sd = 1'b0;
endtask

// ------------------------------
// Codec side
// ------------------------------

logic        bclk_seen   = 1'b0;
logic        lrclk_seen  = 1'b0;
logic [15:0] codec_shift = '0;

// The bit right after an lrclk edge is the LSB of the word before
task automatic decode_codec_sdata ();
    if (!bclk_seen && aud_bclk)
    begin
        codec_shift = { codec_shift [14:0], aud_sdata };

        if (aud_lrclk !== lrclk_seen)
        begin
            if (lrclk_seen)
            begin
                right_word = codec_shift;
                -> frame_decoded;
            end
            else
            begin
                left_word = codec_shift;
            end
            lrclk_seen = aud_lrclk;
        end
    end

    bclk_seen = aud_bclk;
endtask

`endif

// ==== tests/board_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_top_tb;

    import board_pkg::*;
    import audio_pkg::*;

    // Microphone frames (256 clk) come faster than codec frames (384 clk)
    localparam sck_div          = 2;
    localparam bclk_div         = 6;
    localparam tone_half_period = 3;

    logic               clk = 1'b0;
    logic               rst;
    logic [w_key - 1:0] key;
    logic [w_sw  - 1:0] sw;
    logic               mic_sd;
    wire                mic_sck;
    wire                mic_ws;
    wire                mic_lr;
    wire  [w_sw  - 1:0] led;
    segments_t          hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;
    wire                aud_mclk;
    wire                aud_bclk;
    wire                aud_lrclk;
    wire                aud_sdata;

    // Stimulus state shared by the bus model and the comparison
    logic [31:0] rng_state = 32'hd631_32d3;
    int          mic_mode  = 0;
    bit          tone_on   = 1'b0;
    int          tone_amp  = 0;
    bit          checking  = 1'b0;
    mic_sample_t sent_q [$];

    int          error_count   = 0;
    int          test_count    = 0;
    int          failed_tests  = 0;
    int          word_count    = 0;
    int          checked_words = 0;
    int          sat_high      = 0;
    int          sat_low       = 0;
    logic [15:0] last_word     = '0;

    event        frame_decoded;
    logic [15:0] left_word  = '0;
    logic [15:0] right_word = '0;

    logic        mclk_prev = 1'b0;
    logic        rst_prev  = 1'b1;

    always #20 clk = ~ clk;

    board_top
    #(
        .sck_div          ( sck_div          ),
        .bclk_div         ( bclk_div         ),
        .tone_half_period ( tone_half_period )
    )
    dut
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .key       ( key       ),
        .sw        ( sw        ),
        .led       ( led       ),
        .mic_sd    ( mic_sd    ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .mic_lr    ( mic_lr    ),
        .hex0      ( hex0      ),
        .hex1      ( hex1      ),
        .hex2      ( hex2      ),
        .hex3      ( hex3      ),
        .hex4      ( hex4      ),
        .hex5      ( hex5      ),
        .hex6      ( hex6      ),
        .hex7      ( hex7      ),
        .aud_mclk  ( aud_mclk  ),
        .aud_bclk  ( aud_bclk  ),
        .aud_lrclk ( aud_lrclk ),
        .aud_sdata ( aud_sdata )
    );

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic logic [31:0] xorshift (input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Mode 1 gives samples close to positive or negative full scale
    function automatic mic_sample_t next_mic_sample ();
        rng_state = xorshift (rng_state);
        if (mic_mode == 0)
            return mic_sample_t' (rng_state [23:0]);
        else if (rng_state [31])
            return { 12'h7ff, rng_state [11:0] };
        else
            return { 12'h800, rng_state [11:0] };
    endfunction

    function automatic int mixed_ref (input mic_sample_t mic, input int tone);
        int sum;
        sum = (mic >>> 8) + tone;
        if (sum > 32767)
            return 32767;
        else if (sum < -32768)
            return -32768;
        else
            return sum;
    endfunction

    // Square wave starts positive and flips every tone_half_period words
    function automatic int tone_for_word (input int index);
        if (!tone_on)
            return 0;
        else if ((index / tone_half_period) % 2 == 1)
            return - tone_amp * 128;
        else
            return tone_amp * 128;
    endfunction

    // Bit 0 is segment a
    function automatic segments_t segments_of (input logic [3:0] nibble);
        case (nibble)
        4'h0:    return 7'b011_1111;
        4'h1:    return 7'b000_0110;
        4'h2:    return 7'b101_1011;
        4'h3:    return 7'b100_1111;
        4'h4:    return 7'b110_0110;
        4'h5:    return 7'b110_1101;
        4'h6:    return 7'b111_1101;
        4'h7:    return 7'b000_0111;
        4'h8:    return 7'b111_1111;
        4'h9:    return 7'b110_1111;
        4'ha:    return 7'b111_0111;
        4'hb:    return 7'b111_1100;
        4'hc:    return 7'b011_1001;
        4'hd:    return 7'b101_1110;
        4'he:    return 7'b111_1001;
        default: return 7'b111_0001;
        endcase
    endfunction

    // Active-low pattern of hex3 down to hex0
    function automatic logic [27:0] shown_pattern (input logic [15:0] value);
        return { ~ segments_of (value [15:12]), ~ segments_of (value [11:8]),
                 ~ segments_of (value [7:4]),   ~ segments_of (value [3:0]) };
    endfunction

    // ------------------------------
    // Reporting and waiting
    // ------------------------------

    task automatic report_mismatch (input string msg);
        $display ("Mismatch at time %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic report_failure (input string msg);
        $display ("Error: %s", msg);
        error_count++;
    endtask

    task automatic finish_test (input string name, input int errs_at_start);
        test_count++;
        if (error_count == errs_at_start)
        begin
            $display ("Test %0d, %s: ok", test_count, name);
        end
        else
        begin
            failed_tests++;
            $display ("Test %0d, %s: %0d errors", test_count, name, error_count - errs_at_start);
        end
    endtask

    task automatic abort_run (input string reason);
        $display ("%s", reason);
        $display ("Testbench failed");
        $finish;
    endtask

    task automatic wait_words (input int count);
        int target;
        int cycles;
        target = word_count + count;
        cycles = 0;
        while (word_count < target)
        begin
            @ (negedge clk);
            cycles++;
            if (cycles > count * 1000 + 2000)
                abort_run ("Timeout: the codec stopped delivering nonzero words");
        end
    endtask

    // Words right after a control change may still carry the old tone
    task automatic run_phase (input int skip, input int count);
        checking = 1'b0;
        wait_words (skip);
        checking = 1'b1;
        wait_words (count);
        checking = 1'b0;
    endtask

    task automatic apply_controls (input bit press, input logic [7:0] amplitude);
        key [0]  = ~ press;
        sw       = amplitude;
        tone_on  = press;
        tone_amp = amplitude;
    endtask

    `include "i2s_bus_model.svh"

    always @ (negedge clk)
    begin
        drive_mic_sd ();
        decode_codec_sdata ();
    end

    // Codec master clock runs at half the clk rate
    always @ (negedge clk)
    begin
        if (!rst_prev && aud_mclk === mclk_prev)
            report_mismatch ("aud_mclk did not toggle since the last clk cycle");
        if (mic_lr !== 1'b0)
            report_mismatch ("mic_lr is not low");
        mclk_prev = aud_mclk;
        rst_prev  = rst;
    end

    // ------------------------------
    // Comparison of codec frames
    // ------------------------------

    always @ (frame_decoded)
    begin : compare_frame
        int word;
        int tone;
        bit found;

        word = $signed (left_word);
        if (right_word !== left_word)
        begin
            report_mismatch ($sformatf ("left word %h and right word %h differ",
                                        left_word, right_word));
        end
        else if (left_word != 16'h0000)
        begin
            tone = tone_for_word (word_count);
            if (checking)
            begin
                found = 1'b0;
                // Older samples were dropped by an overrun
                while (!found && sent_q.size () > 0)
                begin
                    found = mixed_ref (sent_q [0], tone) == word;
                    sent_q.delete (0);
                end
                if (!found)
                    report_mismatch ($sformatf ("codec word %0d fits no sent sample with tone %0d",
                                                word, tone));
                if (word == 32767)
                    sat_high++;
                if (word == -32768)
                    sat_low++;
                checked_words++;
            end
            last_word  = left_word;
            word_count = word_count + 1;
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial
    begin
        int          errs;
        logic [27:0] shown;

        rst    = 1'b1;
        key    = '1;
        sw     = '0;
        mic_sd = 1'b0;

        errs = error_count;
        repeat (4) @ (negedge clk);
        if ({ hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0 } !== '1)
            report_mismatch ("hex outputs are not blank after reset");
        if (led !== '0)
            report_mismatch ($sformatf ("led is %h after reset", led));
        if (aud_sdata !== 1'b0 || mic_ws !== 1'b0)
            report_mismatch ("aud_sdata or mic_ws is not low after reset");
        if (mic_sck !== 1'b0 || aud_bclk !== 1'b0 || aud_lrclk !== 1'b0 || aud_mclk !== 1'b0)
            report_mismatch ("a serial clock output is not low after reset");
        rst = 1'b0;
        finish_test ("reset state", errs);

        errs = error_count;
        apply_controls (1'b0, 8'h5a);
        run_phase (5, 12);
        finish_test ("microphone only", errs);

        errs = error_count;
        apply_controls (1'b1, 8'h3c);
        run_phase (5, 15);
        finish_test ("microphone with tone", errs);

        errs = error_count;
        apply_controls (1'b1, 8'hff);
        mic_mode = 1;
        sat_high = 0;
        sat_low  = 0;
        run_phase (5, 30);
        if (sat_high == 0)
            report_failure ("no mixed word reached the positive limit");
        if (sat_low == 0)
            report_failure ("no mixed word reached the negative limit");
        finish_test ("saturation", errs);

        // The mixer already holds a newer word when a frame is decoded
        errs = error_count;
        mic_mode = 0;
        apply_controls (1'b1, 8'hc5);
        wait_words (1);
        repeat (w_digit) @ (negedge clk);
        shown = { hex3, hex2, hex1, hex0 };
        if ({ hex5, hex4 } !== { ~ segments_of (sw [7:4]), ~ segments_of (sw [3:0]) })
            report_mismatch ("hex4 and hex5 do not show the switch value");
        if ({ hex7, hex6 } !== { 2 { ~ segments_of (4'h0) } })
            report_mismatch ("hex6 and hex7 do not show zeros");
        wait_words (1);
        if (shown !== shown_pattern (last_word))
        begin
            wait_words (1);
            if (shown !== shown_pattern (last_word))
                report_mismatch ("hex0 to hex3 match neither of the next two codec words");
        end
        finish_test ("display", errs);

        errs = error_count;
        if (led !== 8'h01)
            report_mismatch ($sformatf ("led is %h, overrun flag expected", led));
        finish_test ("overrun flag", errs);

        $display ("Summary: %0d tests, %0d failed, %0d errors, %0d codec words checked",
                  test_count, failed_tests, error_count, checked_words);
        if (error_count == 0)
            $display ("Testbench passed");
        else
            $display ("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_top
#(
    parameter sck_div          = 8,
              bclk_div         = 32,
              tone_half_period = 50
)
(
    input  wire                            clk,
    input  wire                            rst,

    input  wire  [board_pkg::w_key - 1:0]  key,
    input  wire  [board_pkg::w_sw  - 1:0]  sw,
    output logic [board_pkg::w_sw  - 1:0]  led,

    input  wire                            mic_sd,
    output logic                           mic_sck,
    output logic                           mic_ws,
    output logic                           mic_lr,

    output board_pkg::segments_t           hex0,
    output board_pkg::segments_t           hex1,
    output board_pkg::segments_t           hex2,
    output board_pkg::segments_t           hex3,
    output board_pkg::segments_t           hex4,
    output board_pkg::segments_t           hex5,
    output board_pkg::segments_t           hex6,
    output board_pkg::segments_t           hex7,

    output logic                           aud_mclk,
    output logic                           aud_bclk,
    output logic                           aud_lrclk,
    output logic                           aud_sdata
);

    import board_pkg::*;
    import audio_pkg::*;

    // ------------------------------
    // Streams and board-level wires
    // ------------------------------

    sample_if #(.sample_t (mic_sample_t))   mic_bus  ();
    sample_if #(.sample_t (audio_sample_t)) tone_bus ();
    sample_if #(.sample_t (audio_sample_t)) out_bus  ();

    // Keys on the board are active low
    wire tone_enable = ~ key [0];

    wire overrun_seen;

    // Upper two digits stay at zero
    wire [4 * w_digit - 1:0] display_value =
        { {(4 * w_digit - w_sw - audio_bits) {1'b0}}, sw, out_bus.data };

    segments_t [w_digit - 1:0] hex_digits;

    assign led = { {(w_sw - 1) {1'b0}}, overrun_seen };

    assign { hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0 } = hex_digits;

    // ------------------------------
    // Audio path
    // ------------------------------

    i2s_mic_receiver #(.sck_div (sck_div)) i_mic
    (
        .clk     ( clk      ),
        .rst     ( rst      ),
        .sd      ( mic_sd   ),
        .sck     ( mic_sck  ),
        .ws      ( mic_ws   ),
        .lr      ( mic_lr   ),
        .out_bus ( mic_bus  )
    );

    tone_source #(.tone_half_period (tone_half_period)) i_tone
    (
        .clk       ( clk         ),
        .rst       ( rst         ),
        .enable    ( tone_enable ),
        .amplitude ( sw          ),
        .out_bus   ( tone_bus    )
    );

    audio_mixer i_mixer
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .mic_bus      ( mic_bus      ),
        .tone_bus     ( tone_bus     ),
        .out_bus      ( out_bus      ),
        .overrun_seen ( overrun_seen )
    );

    i2s_audio_out #(.bclk_div (bclk_div)) i_codec
    (
        .clk    ( clk       ),
        .rst    ( rst       ),
        .in_bus ( out_bus   ),
        .mclk   ( aud_mclk  ),
        .bclk   ( aud_bclk  ),
        .lrclk  ( aud_lrclk ),
        .sdata  ( aud_sdata )
    );

    // ------------------------------
    // Display
    // ------------------------------

    seven_seg_display i_display
    (
        .clk   ( clk           ),
        .rst   ( rst           ),
        .value ( display_value ),
        .hex   ( hex_digits    )
    );

endmodule

`default_nettype wire

// ==== display/seven_seg_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module seven_seg_display
(
    input  wire                                             clk,
    input  wire                                             rst,
    input  wire  [4 * board_pkg::w_digit - 1:0]             value,
    output board_pkg::segments_t [board_pkg::w_digit - 1:0] hex
);

    import board_pkg::*;

    localparam w_index = w_digit > 1 ? $clog2 (w_digit) : 1;

    logic [w_index - 1:0] digit;
    logic [          3:0] nibble;
    segments_t            pattern;

    assign nibble = value [{ digit, 2'b00 } +: 4];

    // ------------------------------
    // Hex decoder, bit order g to a
    // ------------------------------

    always_comb
    begin
        case (nibble)
        4'h0:    pattern = 7'b011_1111;
        4'h1:    pattern = 7'b000_0110;
        4'h2:    pattern = 7'b101_1011;
        4'h3:    pattern = 7'b100_1111;
        4'h4:    pattern = 7'b110_0110;
        4'h5:    pattern = 7'b110_1101;
        4'h6:    pattern = 7'b111_1101;
        4'h7:    pattern = 7'b000_0111;
        4'h8:    pattern = 7'b111_1111;
        4'h9:    pattern = 7'b110_1111;
        4'ha:    pattern = 7'b111_0111;
        4'hb:    pattern = 7'b111_1100;
        4'hc:    pattern = 7'b011_1001;
        4'hd:    pattern = 7'b101_1110;
        4'he:    pattern = 7'b111_1001;
        default: pattern = 7'b111_0001;
        endcase
    end

    // ------------------------------
    // Scan and sticky registers
    // ------------------------------

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
            digit <= '0;
        else if (digit == w_index' (w_digit - 1))
            digit <= '0;
        else
            digit <= digit + 1'b1;
    end

    // Each digit keeps its pattern until the scan comes back
    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hex <= '1;   // All segments off
        end
        else
        begin
            hex [digit] <= ~ pattern;
        end
    end

endmodule

`default_nettype wire

// ==== source/audio_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_mixer
(
    input  wire      clk,
    input  wire      rst,
    sample_if.sink   mic_bus,
    sample_if.sink   tone_bus,
    sample_if.source out_bus,
    output logic     overrun_seen
);

    import audio_pkg::*;

    mic_sample_t                mic_value;
    mic_sample_t                mic_scaled;
    audio_sample_t              tone_value;
    logic signed [audio_bits:0] sum;
    audio_sample_t              mixed;
    logic                       space;
    logic                       take;

    assign out_bus.overrun = 1'b0;

    // Output register is free or drains this cycle
    assign space = ~ out_bus.valid | out_bus.ready;
    assign take  = space & mic_bus.valid & tone_bus.valid;

    // Both inputs move together or not at all
    assign mic_bus.ready  = space & tone_bus.valid;
    assign tone_bus.ready = space & mic_bus.valid;

    assign mic_value  = mic_bus.data;
    assign tone_value = tone_bus.data;
    assign mic_scaled = mic_value >>> mic_shift;

    // One extra bit holds the carry for saturation
    assign sum = $signed (mic_scaled [audio_bits:0]) + tone_value;

    always_comb
    begin
        if (sum > audio_max)
            mixed = audio_max;
        else if (sum < audio_min)
            mixed = audio_min;
        else
            mixed = audio_sample_t' (sum);
    end

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            out_bus.valid <= 1'b0;
            out_bus.data  <= '0;
            overrun_seen  <= 1'b0;
        end
        else
        begin
            if (take)
            begin
                out_bus.valid <= 1'b1;
                out_bus.data  <= mixed;
            end
            else if (out_bus.ready)
            begin
                out_bus.valid <= 1'b0;
            end

            if (mic_bus.overrun)
                overrun_seen <= 1'b1;
        end
    end

    hold_while_stalled: assert property (
        @ (posedge clk) disable iff (rst)
        out_bus.valid & ~ out_bus.ready |=> out_bus.valid & $stable (out_bus.data)
    );

endmodule

`default_nettype wire

// ==== source/tone_source.sv ====
`timescale 1ns/1ps
`default_nettype none

module tone_source
#(
    parameter tone_half_period = 50
)
(
    input  wire        clk,
    input  wire        rst,
    input  wire        enable,
    input  wire  [7:0] amplitude,
    sample_if.source   out_bus
);

    import audio_pkg::*;

    localparam w_cnt = tone_half_period > 1 ? $clog2 (tone_half_period) : 1;

    logic [w_cnt - 1:0] xfer_cnt;
    logic               level;
    logic               half_done;
    logic               next_level;
    logic               load;
    audio_sample_t      magnitude;

    assign out_bus.overrun = 1'b0;

    assign half_done  = out_bus.valid & out_bus.ready
                      & (xfer_cnt == w_cnt' (tone_half_period - 1));
    assign next_level = level ^ half_done;

    // Fill when empty, refill right after each transfer
    assign load = ~ out_bus.valid | out_bus.ready;

    // Amplitude times 128
    assign magnitude = audio_sample_t' ({ 1'b0, amplitude, 7'b0 });

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            xfer_cnt      <= '0;
            level         <= 1'b0;
            out_bus.valid <= 1'b0;
        end
        else
        begin
            out_bus.valid <= 1'b1;
            level         <= next_level;

            if (out_bus.valid & out_bus.ready)
                xfer_cnt <= half_done ? '0 : xfer_cnt + 1'b1;
        end
    end

    always_ff @ (posedge clk)
    begin
        if (load)
        begin
            if (~ enable)
                out_bus.data <= '0;
            else if (next_level)
                out_bus.data <= - magnitude;
            else
                out_bus.data <= magnitude;
        end
    end

endmodule

`default_nettype wire

// ==== i2s/i2s_audio_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_audio_out
#(
    parameter bclk_div = 32
)
(
    input  wire    clk,
    input  wire    rst,
    sample_if.sink in_bus,
    output logic   mclk,
    output logic   bclk,
    output logic   lrclk,
    output logic   sdata
);

    import audio_pkg::*;

    localparam w_div = bclk_div > 1 ? $clog2 (bclk_div) : 1;

    logic [w_div - 1:0] div_cnt;
    logic               bclk_tick;
    logic               bclk_fall;
    logic [        4:0] bit_cnt;
    logic [        4:0] next_cnt;
    logic [        3:0] slot;
    logic               frame_start;
    audio_sample_t      word;

    assign bclk_tick = div_cnt == w_div' (bclk_div - 1);
    assign bclk_fall = bclk_tick & bclk;

    // Everything on the serial side moves on the falling bclk edge
    assign next_cnt    = bit_cnt + 1'b1;
    assign slot        = next_cnt [3:0];
    assign frame_start = bclk_fall & (next_cnt == '0);

    // One-cycle ready, the sample is taken at frame start only
    assign in_bus.ready = frame_start;

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mclk    <= 1'b0;
            div_cnt <= '0;
            bclk    <= 1'b0;
            bit_cnt <= '1;   // First falling edge opens a frame
            lrclk   <= 1'b0;
            sdata   <= 1'b0;
            word    <= '0;
        end
        else
        begin
            mclk    <= ~ mclk;
            div_cnt <= bclk_tick ? '0 : div_cnt + 1'b1;

            if (bclk_tick)
                bclk <= ~ bclk;

            if (bclk_fall)
            begin
                bit_cnt <= next_cnt;
                lrclk   <= next_cnt [4];

                // Slot 0 of each half still carries the LSB of the word before
                if (slot == 4'd0)
                    sdata <= word [0];
                else
                    sdata <= word [audio_bits - slot];
            end

            // Nothing ready at frame start means a silent frame
            if (frame_start)
                word <= in_bus.valid ? in_bus.data : '0;
        end
    end

endmodule

`default_nettype wire

// ==== i2s/i2s_mic_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_mic_receiver
#(
    parameter sck_div = 8
)
(
    input  wire      clk,
    input  wire      rst,
    input  wire      sd,
    output logic     sck,
    output logic     ws,
    output logic     lr,
    sample_if.source out_bus
);

    import audio_pkg::*;

    localparam w_div = sck_div > 1 ? $clog2 (sck_div) : 1;

    logic [w_div - 1:0] div_cnt;
    logic               sck_tick;
    logic               sck_rise;
    logic               sck_fall;
    logic [        5:0] bit_cnt;
    logic               capture;
    logic               last_bit;
    logic               sample_done;
    mic_sample_t        shift_reg;

    // Microphone answers in the left slot
    assign lr = 1'b0;

    assign sck_tick = div_cnt == w_div' (sck_div - 1);
    assign sck_rise = sck_tick & ~ sck;
    assign sck_fall = sck_tick &   sck;

    // Bit counter counts sck periods, the upper half is the right channel
    assign ws = bit_cnt [5];

    // Data bits sit in periods 1 to 24 of the left half
    assign capture  = sck_rise & (bit_cnt >= 6'd1) & (bit_cnt <= 6' (mic_bits));
    assign last_bit = sck_rise & (bit_cnt == 6' (mic_bits));

    // ------------------------------
    // Serial clocks and handshake
    // ------------------------------

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt         <= '0;
            sck             <= 1'b0;
            bit_cnt         <= '0;
            sample_done     <= 1'b0;
            out_bus.valid   <= 1'b0;
            out_bus.overrun <= 1'b0;
        end
        else
        begin
            div_cnt <= sck_tick ? '0 : div_cnt + 1'b1;

            if (sck_tick)
                sck <= ~ sck;

            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;

            sample_done <= last_bit;

            // The old sample is still waiting, it gets replaced
            out_bus.overrun <= sample_done & out_bus.valid & ~ out_bus.ready;

            if (sample_done)
                out_bus.valid <= 1'b1;
            else if (out_bus.ready)
                out_bus.valid <= 1'b0;
        end
    end

    // ------------------------------
    // Payload
    // ------------------------------

    always_ff @ (posedge clk)
    begin
        if (capture)
            shift_reg <= { shift_reg [mic_bits - 2:0], sd };

        if (sample_done)
            out_bus.data <= shift_reg;
    end

    sck_on_wrap: assert property (
        @ (posedge clk) disable iff (rst)
        $changed (sck) |-> $past (sck_tick)
    );

endmodule

`default_nettype wire

// ==== common/sample_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Sample stream with valid/ready handshake
interface sample_if
#(
    parameter type sample_t = logic [15:0]
);

    logic    valid;
    logic    ready;
    sample_t data;

    // One-cycle pulse when the source lost a sample
    logic    overrun;

    modport source
    (
        output valid,
        output data,
        output overrun,
        input  ready
    );

    modport sink
    (
        input  valid,
        input  data,
        input  overrun,
        output ready
    );

endinterface

`default_nettype wire

// ==== common/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

    // ------------------------------
    // Sample widths
    // ------------------------------

    localparam mic_bits   = 24;
    localparam audio_bits = 16;

    typedef logic signed [mic_bits   - 1:0] mic_sample_t;
    typedef logic signed [audio_bits - 1:0] audio_sample_t;

    // ------------------------------
    // Mixing constants
    // ------------------------------

    // Drops the low microphone bits to land in the codec range
    localparam mic_shift = 8;

    localparam audio_sample_t audio_max = 16'sh7fff;
    localparam audio_sample_t audio_min = 16'sh8000;

endpackage

`default_nettype wire

// ==== common/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // ------------------------------
    // Board I/O geometry
    // ------------------------------

    localparam w_key   = 4;
    localparam w_sw    = 8;
    localparam w_digit = 8;

    // ------------------------------
    // Display types
    // ------------------------------

    // Bit 0 is segment a, bit 6 is segment g
    typedef logic [6:0] segments_t;

endpackage

`default_nettype wire
